// ==== mcu_bus_pkg.sv ====
// MCU peripheral bus definitions
// CPU data bus, host bridge access and the register map of the peripheral window

package mcu_bus_pkg;

	// CPU data bus command, accepted every cycle
	typedef struct packed {
		logic        valid;
		logic        wr;    // 1 = store, 0 = load
		logic [31:0] addr;
		logic [31:0] data;  // Store data
	} dbus_cmd_t;

	// CPU response, one edge after the command
	typedef struct packed {
		logic        ready;
		logic [31:0] data;  // Load data, zero for stores
	} dbus_rsp_t;

	// Host bridge access, on clk_sys
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [31:0] addr;
		logic [31:0] data;
	} bridge_req_t;

	// Decoded write handed to each peripheral block
	typedef struct packed {
		logic        en;   // Window hit and store
		logic [7:0]  ofs;  // Byte offset inside the window
		logic [31:0] data;
	} periph_wr_t;

	localparam logic [15:0] PERIPH_WINDOW = 16'hFFFF; // Address bits 31..16

	// Register offsets in the window
	localparam logic [7:0] OFS_INTERACT_BASE = 8'h00; // Shared interaction bank
	localparam logic [7:0] OFS_DS_ID         = 8'h80;
	localparam logic [7:0] OFS_DS_BRIDGEADDR = 8'h84;
	localparam logic [7:0] OFS_DS_LENGTH     = 8'h88;
	localparam logic [7:0] OFS_DS_SLOTOFFSET = 8'h8C;
	localparam logic [7:0] OFS_DS_CTRL       = 8'h90; // Command on write, status on read
	localparam logic [7:0] OFS_SYSCLK_FREQ   = 8'h98; // Ticks per millisecond minus one
	localparam logic [7:0] OFS_RESET_OUT     = 8'hA4;
	localparam logic [7:0] OFS_TIMER_COUNT   = 8'hC4;
	localparam logic [7:0] OFS_TIMER_COMPARE = 8'hC8;
	localparam logic [7:0] OFS_TIMER_MASK    = 8'hF4;

endpackage

// ==== mcu_dataslot_pkg.sv ====
// Target dataslot types
// Command to the host, status back from it, and the control word at OFS_DS_CTRL

package mcu_dataslot_pkg;

	// Outgoing dataslot command and its parameters
	typedef struct packed {
		logic        read;       // One-cycle strobe
		logic        write;      // One-cycle strobe
		logic [15:0] id;         // Asset id
		logic [31:0] slotoffset;
		logic [31:0] bridgeaddr; // Destination in bridge space
		logic [31:0] length;
	} ds_cmd_t;

	// Status driven by the host
	typedef struct packed {
		logic       ack;  // Command in progress
		logic       done; // Held until the next command
		logic [2:0] err;  // Zero is OK
	} ds_status_t;

	// Control word as the CPU writes it
	typedef struct packed {
		logic [28:0] rsvd;
		logic        irq_enable;
		logic        write;
		logic        read;
	} ds_ctrl_cmd_t;

	// Same word as the CPU reads it back
	typedef struct packed {
		logic [26:0] rsvd;
		logic        ack;
		logic        done;
		logic [2:0]  err;
	} ds_ctrl_stat_t;

	typedef union packed {
		ds_ctrl_cmd_t  cmd;
		ds_ctrl_stat_t stat;
	} ds_ctrl_u;

endpackage

// ==== mcu_interact_regs.sv ====
// Shared interaction register bank
// Written and read by both the host bridge and the CPU, bridge has priority

module mcu_interact_regs import mcu_bus_pkg::*; #(
	parameter int          INTERACT_COUNT = 8,           // Power of two, 2 to 32
	parameter logic [23:0] BRIDGE_BASE    = 24'h810000   // Bridge address bits 31..8
) (
	input  logic        clk_sys,
	input  logic        reset_n,
	input  bridge_req_t bridge,
	output logic [31:0] bridge_rd_data,
	input  periph_wr_t  cpu_wr,
	input  logic [7:0]  rd_ofs,
	output logic [31:0] rd_data,
	output logic        rd_hit
);
	localparam int IDX_W = $clog2(INTERACT_COUNT);
	localparam int SPAN  = INTERACT_COUNT * 4; // Bytes covered by the bank

	logic [31:0]      regs [INTERACT_COUNT];
	logic [7:0]       cpu_wr_rel;
	logic [7:0]       cpu_rd_rel;
	logic             cpu_wr_hit;
	logic             br_sel;      // Bridge address inside the bank
	logic [IDX_W-1:0] br_idx;
	logic [31:0]      br_rd_q1;    // First read stage

	// Offsets relative to the bank base
	assign cpu_wr_rel = cpu_wr.ofs - OFS_INTERACT_BASE;
	assign cpu_rd_rel = rd_ofs - OFS_INTERACT_BASE;
	assign cpu_wr_hit = cpu_wr.en && (cpu_wr_rel < SPAN) && (cpu_wr_rel[1:0] == 2'b00);

	assign br_sel = (bridge.addr[31:8] == BRIDGE_BASE) && (bridge.addr[7:0] < SPAN)
		&& (bridge.addr[1:0] == 2'b00);
	assign br_idx = bridge.addr[IDX_W+1:2];

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < INTERACT_COUNT; i++) begin
				regs[i] <= '0;
			end
			br_rd_q1       <= '0;
			bridge_rd_data <= '0;
		end else begin
			if (cpu_wr_hit) begin
				regs[cpu_wr_rel[IDX_W+1:2]] <= cpu_wr.data;
			end
			if (bridge.wr && br_sel) begin
				regs[br_idx] <= bridge.data; // Last assignment, bridge wins a collision
			end
			if (bridge.rd) begin
				br_rd_q1 <= br_sel ? regs[br_idx] : '0;
			end
			bridge_rd_data <= br_rd_q1; // Second stage
		end
	end

	// CPU read path, registered in the top
	assign rd_hit  = (cpu_rd_rel < SPAN) && (cpu_rd_rel[1:0] == 2'b00);
	assign rd_data = rd_hit ? regs[cpu_rd_rel[IDX_W+1:2]] : '0;

endmodule

// ==== mcu_ms_timer.sv ====
// Millisecond timer
// Tick prescaler from sysclk_frequency, millisecond count and compare interrupt

module mcu_ms_timer import mcu_bus_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset_n,
	input  periph_wr_t  cpu_wr,
	input  logic [7:0]  rd_ofs,
	output logic [31:0] rd_data,
	output logic        rd_hit,
	output logic        timer_irq
);
	logic [31:0] sysclk_frequency; // Tick wrap value
	logic [31:0] compare;
	logic        enable;
	logic        mask;
	logic [31:0] tick;
	logic [31:0] ms_count;
	logic        irq_int;          // Compare reached, before enable and mask

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			sysclk_frequency <= '0;
			compare          <= '0;
			enable           <= 1'b0;
			mask             <= 1'b0;
			tick             <= '0;
			ms_count         <= '0;
			irq_int          <= 1'b0;
			timer_irq        <= 1'b0;
		end else begin
			tick <= tick + 32'd1;
			if (tick == sysclk_frequency) begin // One millisecond elapsed
				tick     <= '0;
				ms_count <= ms_count + 32'd1;
				if (compare != '0 && ms_count >= compare) irq_int <= 1'b1;
			end
			if (cpu_wr.en) begin
				case (cpu_wr.ofs)
					OFS_SYSCLK_FREQ:   sysclk_frequency <= cpu_wr.data;
					OFS_TIMER_MASK:    mask             <= cpu_wr.data[0];
					OFS_TIMER_COMPARE: begin
						compare <= cpu_wr.data;
						enable  <= 1'b1; // Arming the compare enables it
					end
					OFS_TIMER_COUNT: begin
						enable <= 1'b0;
						if (cpu_wr.data[0]) begin // Restart overrides the tick above
							tick     <= '0;
							ms_count <= '0;
							irq_int  <= 1'b0;
						end
					end
					default: ;
				endcase
			end
			timer_irq <= irq_int && enable && mask; // One cycle behind irq_int
		end
	end

	// Readback
	always_comb begin
		rd_hit = 1'b1;
		case (rd_ofs)
			OFS_SYSCLK_FREQ:   rd_data = sysclk_frequency;
			OFS_TIMER_COUNT:   rd_data = ms_count;
			OFS_TIMER_COMPARE: rd_data = compare;
			OFS_TIMER_MASK:    rd_data = {29'h0, irq_int, enable, mask};
			default: begin
				rd_data = '0;
				rd_hit  = 1'b0;
			end
		endcase
	end

endmodule

// ==== mcu_dataslot_target.sv ====
// Target dataslot command block
// Parameter registers, one-cycle read/write strobes, live status and done interrupt

module mcu_dataslot_target import mcu_bus_pkg::*, mcu_dataslot_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset_n,
	input  periph_wr_t  cpu_wr,
	input  logic [7:0]  rd_ofs,
	output logic [31:0] rd_data,
	output logic        rd_hit,
	output ds_cmd_t     ds_cmd,
	input  ds_status_t  ds_status,
	output logic        ext_irq
);
	ds_ctrl_u ctrl_wr;    // Command view of the written word
	ds_ctrl_u ctrl_rd;    // Status view for readback
	logic     irq_enable;
	logic     done_q;     // Previous done, for edge detect

	assign ctrl_wr = cpu_wr.data;

	always_comb begin
		ctrl_rd          = '0;
		ctrl_rd.stat.ack  = ds_status.ack;
		ctrl_rd.stat.done = ds_status.done;
		ctrl_rd.stat.err  = ds_status.err;
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			ds_cmd     <= '0;
			irq_enable <= 1'b0;
			done_q     <= 1'b0;
			ext_irq    <= 1'b0;
		end else begin
			ds_cmd.read  <= 1'b0; // Strobes drop after one cycle
			ds_cmd.write <= 1'b0;
			done_q       <= ds_status.done;
			ext_irq      <= ds_status.done && !done_q && irq_enable; // Rising edge only
			if (cpu_wr.en) begin
				case (cpu_wr.ofs)
					OFS_DS_ID:         ds_cmd.id         <= cpu_wr.data[15:0]; // Upper half dropped
					OFS_DS_BRIDGEADDR: ds_cmd.bridgeaddr <= cpu_wr.data;
					OFS_DS_LENGTH:     ds_cmd.length     <= cpu_wr.data;
					OFS_DS_SLOTOFFSET: ds_cmd.slotoffset <= cpu_wr.data;
					OFS_DS_CTRL: begin
						irq_enable   <= ctrl_wr.cmd.irq_enable;
						ds_cmd.read  <= ctrl_wr.cmd.read;
						ds_cmd.write <= ctrl_wr.cmd.write;
					end
					default: ;
				endcase
			end
		end
	end

	// Readback of parameters and live status
	always_comb begin
		rd_hit = 1'b1;
		case (rd_ofs)
			OFS_DS_ID:         rd_data = {16'h0, ds_cmd.id};
			OFS_DS_BRIDGEADDR: rd_data = ds_cmd.bridgeaddr;
			OFS_DS_LENGTH:     rd_data = ds_cmd.length;
			OFS_DS_SLOTOFFSET: rd_data = ds_cmd.slotoffset;
			OFS_DS_CTRL:       rd_data = ctrl_rd;
			default: begin
				rd_data = '0;
				rd_hit  = 1'b0;
			end
		endcase
	end

endmodule

// ==== mcu_periph_top.sv ====
// MCU peripheral window top
// Decodes the CPU data bus into the top 64 KB window, muxes block reads
// and answers every command one edge later

module mcu_periph_top import mcu_bus_pkg::*, mcu_dataslot_pkg::*; #(
	parameter int          INTERACT_COUNT = 8,
	parameter logic [23:0] BRIDGE_BASE    = 24'h810000
) (
	input  logic        clk_sys,
	input  logic        reset_n,
	input  dbus_cmd_t   cpu_cmd,
	output dbus_rsp_t   cpu_rsp,
	input  bridge_req_t bridge,
	output logic [31:0] bridge_rd_data,
	output ds_cmd_t     ds_cmd,
	input  ds_status_t  ds_status,
	output logic        ext_irq,
	output logic        timer_irq,
	output logic        reset_out
);
	logic        in_window;
	logic        rd_req;        // Load inside the window
	periph_wr_t  cpu_wr;
	logic [7:0]  rd_ofs;
	logic [31:0] ia_data;
	logic [31:0] ds_data;
	logic [31:0] tm_data;
	logic [31:0] rd_word;
	logic        ia_hit;
	logic        ds_hit;
	logic        tm_hit;

	// Single window decode, blocks only see the offset
	assign in_window   = cpu_cmd.addr[31:16] == PERIPH_WINDOW;
	assign rd_req      = cpu_cmd.valid && !cpu_cmd.wr && in_window;
	assign cpu_wr.en   = cpu_cmd.valid && cpu_cmd.wr && in_window;
	assign cpu_wr.ofs  = cpu_cmd.addr[7:0];
	assign cpu_wr.data = cpu_cmd.data;
	assign rd_ofs      = cpu_cmd.addr[7:0];

	mcu_interact_regs #(
		.INTERACT_COUNT (INTERACT_COUNT),
		.BRIDGE_BASE    (BRIDGE_BASE)
	) i_interact (
		.clk_sys (clk_sys), .reset_n (reset_n),
		.bridge  (bridge),  .bridge_rd_data (bridge_rd_data),
		.cpu_wr  (cpu_wr),  .rd_ofs (rd_ofs),
		.rd_data (ia_data), .rd_hit (ia_hit)
	);

	mcu_dataslot_target i_dataslot (
		.clk_sys (clk_sys), .reset_n (reset_n),
		.cpu_wr  (cpu_wr),  .rd_ofs (rd_ofs),
		.rd_data (ds_data), .rd_hit (ds_hit),
		.ds_cmd  (ds_cmd),  .ds_status (ds_status),
		.ext_irq (ext_irq)
	);

	mcu_ms_timer i_timer (
		.clk_sys (clk_sys), .reset_n (reset_n),
		.cpu_wr  (cpu_wr),  .rd_ofs (rd_ofs),
		.rd_data (tm_data), .rd_hit (tm_hit),
		.timer_irq (timer_irq)
	);

	// Read select, zero outside the window or on unmapped offsets
	always_comb begin
		rd_word = '0;
		if (rd_req) begin
			if (ia_hit)                       rd_word = ia_data;
			else if (ds_hit)                  rd_word = ds_data;
			else if (tm_hit)                  rd_word = tm_data;
			else if (rd_ofs == OFS_RESET_OUT) rd_word = {31'h0, reset_out};
		end
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			cpu_rsp   <= '0;
			reset_out <= 1'b0;
		end else begin
			cpu_rsp.ready <= cpu_cmd.valid; // Every command answered, no stalls
			cpu_rsp.data  <= rd_word;
			if (cpu_wr.en && cpu_wr.ofs == OFS_RESET_OUT) begin
				reset_out <= cpu_wr.data[0]; // Core reset request
			end
		end
	end

endmodule

// ==== tb_mcu_periph.sv ====
// Testbench for the MCU peripheral window
// Directed tests over the interaction bank, dataslot block, timer and reset-out

module tb_mcu_periph import mcu_bus_pkg::*, mcu_dataslot_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          INTERACT_COUNT = 8;
	localparam logic [23:0] BRIDGE_BASE    = 24'h810000;
	localparam int          TIMEOUT_CYCLES = 4000; // Tests need well under 1000 cycles

	logic        clk_sys = 1'b0;
	logic        reset_n;
	dbus_cmd_t   cpu_cmd;
	dbus_rsp_t   cpu_rsp;
	bridge_req_t bridge;
	logic [31:0] bridge_rd_data;
	ds_cmd_t     ds_cmd;
	ds_status_t  ds_status;
	logic        ext_irq, timer_irq, reset_out;
	int          errors = 0;
	int          tests_failed = 0;
	int          tests_run = 0;
	int          cycles = 0;
	logic [31:0] lcg_state = 32'd54;

	always #5 clk_sys = ~clk_sys; // 10 ns period

	mcu_periph_top #(.INTERACT_COUNT(INTERACT_COUNT), .BRIDGE_BASE(BRIDGE_BASE)) i_dut (
		.clk_sys (clk_sys), .reset_n (reset_n),
		.cpu_cmd (cpu_cmd), .cpu_rsp (cpu_rsp),
		.bridge (bridge), .bridge_rd_data (bridge_rd_data),
		.ds_cmd (ds_cmd), .ds_status (ds_status),
		.ext_irq (ext_irq), .timer_irq (timer_irq), .reset_out (reset_out)
	);

	always @(posedge clk_sys) begin // Run limit
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] cpu_addr(logic [7:0] ofs);
		return {PERIPH_WINDOW, 8'h00, ofs}; // Inside the top 64 KB
	endfunction

	task automatic check_word(string msg, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(string msg, logic got, logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic check_cmd(string msg, ds_cmd_t got, ds_cmd_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic check_range(string msg, int got, int lo, int hi);
		if (got < lo || got > hi) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d..%0d", $time, msg, got, lo, hi);
			errors++;
		end
	endtask

	task automatic end_test(string name, int err_start);
		tests_run++;
		if (errors == err_start) $display("Test %s: ok", name);
		else begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - err_start);
		end
	endtask

	// One command, ready expected exactly one edge later
	task automatic cpu_access(logic wr, logic [31:0] addr, logic [31:0] data,
		output logic [31:0] rdata);
		@(posedge clk_sys);
		cpu_cmd <= {1'b1, wr, addr, data};
		@(negedge clk_sys);
		check_bit("cpu_rsp.ready before the command edge", cpu_rsp.ready, 1'b0);
		@(posedge clk_sys);
		cpu_cmd <= '0;
		@(negedge clk_sys);
		check_bit("cpu_rsp.ready one edge after the command", cpu_rsp.ready, 1'b1);
		rdata = cpu_rsp.data;
	endtask

	task automatic cpu_write(logic [31:0] addr, logic [31:0] data);
		logic [31:0] unused;
		cpu_access(1'b1, addr, data, unused);
	endtask

	task automatic cpu_read(logic [31:0] addr, output logic [31:0] data);
		cpu_access(1'b0, addr, '0, data);
	endtask

	task automatic bridge_write(logic [7:0] ofs, logic [31:0] data);
		@(posedge clk_sys);
		bridge <= {1'b0, 1'b1, BRIDGE_BASE, ofs, data};
		@(posedge clk_sys);
		bridge <= '0;
	endtask

	task automatic bridge_read(logic [7:0] ofs, output logic [31:0] data);
		@(posedge clk_sys);
		bridge <= {1'b1, 1'b0, BRIDGE_BASE, ofs, 32'h0};
		@(posedge clk_sys); // rd sampled here
		bridge <= '0;
		@(posedge clk_sys); // Second register stage
		@(negedge clk_sys);
		data = bridge_rd_data;
	endtask

	task automatic test_reset();
		logic [7:0]  ofs_list [10] = '{8'h00, 8'h1C, OFS_DS_ID, OFS_DS_BRIDGEADDR, OFS_DS_LENGTH,
			OFS_DS_SLOTOFFSET, OFS_SYSCLK_FREQ, OFS_RESET_OUT, OFS_TIMER_COMPARE, OFS_TIMER_MASK};
		logic [31:0] rd;
		int          e0;
		e0 = errors;
		@(negedge clk_sys);
		check_bit("cpu_rsp.ready after reset", cpu_rsp.ready, 1'b0);
		check_bit("ds_cmd.read after reset", ds_cmd.read, 1'b0);
		check_bit("ds_cmd.write after reset", ds_cmd.write, 1'b0);
		check_bit("ext_irq after reset", ext_irq, 1'b0);
		check_bit("timer_irq after reset", timer_irq, 1'b0);
		check_bit("reset_out after reset", reset_out, 1'b0);
		foreach (ofs_list[i]) begin // Count is free running, left out
			cpu_read(cpu_addr(ofs_list[i]), rd);
			check_word($sformatf("reset value at offset %h", ofs_list[i]), rd, 32'h0);
		end
		end_test("reset", e0);
	endtask

	task automatic test_interact();
		logic [31:0] vals [INTERACT_COUNT];
		logic [31:0] rd, v_br, v_cpu;
		int          e0;
		e0 = errors;
		for (int i = 0; i < INTERACT_COUNT; i++) begin
			vals[i] = lcg_next();
			bridge_write(8'(i * 4), vals[i]);
		end
		for (int i = 0; i < INTERACT_COUNT; i++) begin
			cpu_read(cpu_addr(8'(i * 4)), rd);
			check_word($sformatf("CPU read of bridge write %0d", i), rd, vals[i]);
		end
		for (int i = 0; i < INTERACT_COUNT; i++) begin
			vals[i] = lcg_next();
			cpu_write(cpu_addr(8'(i * 4)), vals[i]);
		end
		for (int i = 0; i < INTERACT_COUNT; i++) begin
			bridge_read(8'(i * 4), rd);
			check_word($sformatf("bridge read of CPU write %0d", i), rd, vals[i]);
		end
		v_br  = lcg_next(); // Same register from both sides in one cycle
		v_cpu = lcg_next();
		@(posedge clk_sys);
		cpu_cmd <= {1'b1, 1'b1, cpu_addr(8'h0C), v_cpu};
		bridge  <= {1'b0, 1'b1, BRIDGE_BASE, 8'h0C, v_br};
		@(posedge clk_sys);
		cpu_cmd <= '0;
		bridge  <= '0;
		cpu_read(cpu_addr(8'h0C), rd);
		check_word("collision keeps bridge value", rd, v_br);
		end_test("interaction registers", e0);
	endtask

	task automatic test_ds_cmd();
		ds_cmd_t     exp;
		ds_status_t  st_list [2];
		logic [31:0] id, rd;
		int          e0;
		e0  = errors;
		exp = '0;
		id  = lcg_next();
		exp.id         = id[15:0]; // Upper half dropped
		exp.bridgeaddr = lcg_next();
		exp.length     = lcg_next();
		exp.slotoffset = lcg_next();
		cpu_write(cpu_addr(OFS_DS_ID), id);
		cpu_write(cpu_addr(OFS_DS_BRIDGEADDR), exp.bridgeaddr);
		cpu_write(cpu_addr(OFS_DS_LENGTH), exp.length);
		cpu_write(cpu_addr(OFS_DS_SLOTOFFSET), exp.slotoffset);
		cpu_write(cpu_addr(OFS_DS_CTRL), 32'h1); // Read command
		exp.read = 1'b1;
		check_cmd("ds_cmd with read strobe", ds_cmd, exp);
		@(negedge clk_sys);
		exp.read = 1'b0;
		check_cmd("ds_cmd after read strobe", ds_cmd, exp);
		cpu_write(cpu_addr(OFS_DS_CTRL), 32'h2); // Write command
		exp.write = 1'b1;
		check_cmd("ds_cmd with write strobe", ds_cmd, exp);
		@(negedge clk_sys);
		exp.write = 1'b0;
		check_cmd("ds_cmd after write strobe", ds_cmd, exp);
		st_list[0] = '{ack: 1'b1, done: 1'b0, err: 3'b101};
		st_list[1] = '{ack: 1'b0, done: 1'b1, err: 3'b010}; // Complement of the first
		foreach (st_list[i]) begin
			@(posedge clk_sys);
			ds_status <= st_list[i];
			cpu_read(cpu_addr(OFS_DS_CTRL), rd);
			check_word($sformatf("status readback %0d", i), rd,
				{27'h0, st_list[i].ack, st_list[i].done, st_list[i].err});
		end
		@(posedge clk_sys);
		ds_status <= '0;
		end_test("dataslot command", e0);
	endtask

	task automatic test_done_irq();
		int e0;
		e0 = errors;
		cpu_write(cpu_addr(OFS_DS_CTRL), 32'h4); // irq_enable only
		@(posedge clk_sys);
		ds_status.done <= 1'b1;
		@(negedge clk_sys);
		check_bit("ext_irq before done is sampled", ext_irq, 1'b0);
		@(negedge clk_sys);
		check_bit("ext_irq one edge after done", ext_irq, 1'b1);
		repeat (3) begin // Pulse is one cycle only
			@(negedge clk_sys);
			check_bit("ext_irq after the pulse", ext_irq, 1'b0);
		end
		@(posedge clk_sys);
		ds_status.done <= 1'b0;
		cpu_write(cpu_addr(OFS_DS_CTRL), 32'h0);
		@(posedge clk_sys);
		ds_status.done <= 1'b1;
		repeat (4) begin
			@(negedge clk_sys);
			check_bit("ext_irq with irq_enable clear", ext_irq, 1'b0);
		end
		@(posedge clk_sys);
		ds_status.done <= 1'b0;
		end_test("done interrupt", e0);
	endtask

	task automatic test_timer();
		logic [31:0] rd;
		int          n, e0;
		e0 = errors;
		cpu_write(cpu_addr(OFS_SYSCLK_FREQ), 32'd9); // 10 cycles per ms
		cpu_write(cpu_addr(OFS_TIMER_COUNT), 32'h1);
		repeat (200) @(posedge clk_sys);
		cpu_read(cpu_addr(OFS_TIMER_COUNT), rd);
		check_range("ms count after 200 cycles", int'(rd), 19, 21);
		cpu_write(cpu_addr(OFS_TIMER_COUNT), 32'h1);
		cpu_read(cpu_addr(OFS_TIMER_COUNT), rd);
		check_word("ms count after restart", rd, 32'h0);
		cpu_write(cpu_addr(OFS_TIMER_MASK), 32'h1);
		cpu_write(cpu_addr(OFS_TIMER_COMPARE), 32'd3); // Sets enable
		n = 0;
		while (timer_irq !== 1'b1 && n < 100) begin
			@(negedge clk_sys);
			n++;
		end
		if (timer_irq !== 1'b1) begin
			$display("Error at %0t: timer_irq did not rise within 100 cycles", $time);
			errors++;
		end else check_range("timer_irq delay after compare write", n, 30, 42);
		cpu_write(cpu_addr(OFS_TIMER_COUNT), 32'h1); // Clears irq and enable
		cpu_write(cpu_addr(OFS_TIMER_MASK), 32'h0);
		cpu_write(cpu_addr(OFS_TIMER_COMPARE), 32'd3);
		repeat (60) begin
			@(negedge clk_sys);
			check_bit("timer_irq with mask clear", timer_irq, 1'b0);
		end
		end_test("timer", e0);
	endtask

	task automatic test_reset_out();
		logic [31:0] rd;
		int          e0;
		e0 = errors;
		cpu_write(cpu_addr(OFS_RESET_OUT), 32'h1);
		check_bit("reset_out after writing 1", reset_out, 1'b1);
		cpu_write(cpu_addr(OFS_RESET_OUT), 32'h0);
		check_bit("reset_out after writing 0", reset_out, 1'b0);
		cpu_read(cpu_addr(8'h60), rd);
		check_word("unmapped offset 0x60", rd, 32'h0);
		cpu_read(32'h1234_0000, rd); // Outside the window
		check_word("address outside the window", rd, 32'h0);
		end_test("reset out and unmapped reads", e0);
	endtask

	initial begin
		reset_n   = 1'b0;
		cpu_cmd   = '0;
		bridge    = '0;
		ds_status = '0;
		repeat (4) @(posedge clk_sys);
		reset_n <= 1'b1;
		test_reset();
		test_interact();
		test_ds_cmd();
		test_done_irq();
		test_timer();
		test_reset_out();
		$display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) $display("Simulation passed");
		else $display("Simulation failed");
		$finish;
	end

endmodule

// ==== mcu_periph.f ====
mcu_bus_pkg.sv
mcu_dataslot_pkg.sv
mcu_interact_regs.sv
mcu_ms_timer.sv
mcu_dataslot_target.sv
mcu_periph_top.sv
tb_mcu_periph.sv

// ==== Bender.yml ====
package:
  name: mcu_periph

sources:
  - mcu_bus_pkg.sv
  - mcu_dataslot_pkg.sv
  - mcu_interact_regs.sv
  - mcu_ms_timer.sv
  - mcu_dataslot_target.sv
  - mcu_periph_top.sv
  - target: test
    files:
      - tb_mcu_periph.sv
